// File: Bender.yml
package:
  name: lc4_pipeline

sources:
  - include_dirs:
      - hw
    files:
      - hw/lc4_pkg.sv
      - hw/lc4_decoder.sv
      - hw/lc4_regfile.sv
      - hw/lc4_alu.sv
      - hw/lc4_branch_unit.sv
      - hw/lc4_hazard_unit.sv
      - hw/lc4_pipeline.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/lc4_pipeline_tb.sv

// File: hw/lc4_alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "lc4_config.svh"

module lc4_alu (
   input  wire lc4_pkg::word_t i_insn,
   input  wire lc4_pkg::word_t i_pc,
   input  wire lc4_pkg::word_t i_r1data,
   input  wire lc4_pkg::word_t i_r2data,
   output lc4_pkg::word_t      o_result
);

   lc4_pkg::word_t imm5;
   lc4_pkg::word_t imm6;
   lc4_pkg::word_t imm9;
   lc4_pkg::word_t imm11;
   lc4_pkg::word_t pc_inc;

   assign imm5   = {{(`LC4_WORD_W-5){i_insn[4]}}, i_insn[4:0]};
   assign imm6   = {{(`LC4_WORD_W-6){i_insn[5]}}, i_insn[5:0]};
   assign imm9   = {{(`LC4_WORD_W-9){i_insn[8]}}, i_insn[8:0]};
   assign imm11  = {{(`LC4_WORD_W-11){i_insn[10]}}, i_insn[10:0]};
   assign pc_inc = i_pc + 1'b1;

   always_comb begin
      case (lc4_pkg::opcode_e'(i_insn[15:12]))
         lc4_pkg::OP_ARITH: begin
            if (i_insn[5]) begin
               o_result = i_r1data + imm5;
            end else if (i_insn[4:3] == 2'b10) begin
               o_result = i_r1data - i_r2data;
            end else if (i_insn[4:3] == 2'b00) begin
               o_result = i_r1data + i_r2data;
            end else begin
               o_result = '0;  // MUL, DIV
            end
         end
         lc4_pkg::OP_LOGIC: begin
            if (i_insn[5]) begin
               o_result = i_r1data & imm5;
            end else begin
               case (i_insn[4:3])
                  2'b00:   o_result = i_r1data & i_r2data;
                  2'b01:   o_result = ~i_r1data;
                  2'b10:   o_result = i_r1data | i_r2data;
                  default: o_result = i_r1data ^ i_r2data;
               endcase
            end
         end
         lc4_pkg::OP_LDR,
         lc4_pkg::OP_STR:   o_result = i_r1data + imm6;  // effective address
         lc4_pkg::OP_CONST: o_result = imm9;
         lc4_pkg::OP_BR:    o_result = pc_inc + imm9;    // branch target
         lc4_pkg::OP_JMP:   o_result = pc_inc + imm11;
         default:           o_result = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: hw/lc4_branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "lc4_config.svh"

module lc4_branch_unit (
   input  wire                 gwe,
   input  wire                 i_arst_n,
   input  wire lc4_pkg::word_t i_x_insn,
   input  wire                 i_x_is_branch,
   input  wire                 i_x_is_jmp,
   input  wire                 i_m_nzp_we,
   input  wire lc4_pkg::word_t i_m_value,  // load data or ALU result
   output lc4_pkg::nzp_t       o_m_nzp,
   output logic                o_taken
);

   lc4_pkg::nzp_t nzp_q;
   lc4_pkg::nzp_t nzp_x;  // condition seen by the branch in execute

   assign o_m_nzp = i_m_value[`LC4_WORD_W-1] ? 3'b100 :
                    (i_m_value == '0)        ? 3'b010 :
                                               3'b001;

   // no flag set out of reset, so a conditional BR falls through
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         nzp_q <= '0;
      end else if (i_m_nzp_we) begin
         nzp_q <= o_m_nzp;
      end
   end

   // the instruction one ahead in memory forwards its flags
   assign nzp_x = i_m_nzp_we ? o_m_nzp : nzp_q;

   assign o_taken = i_x_is_jmp || (i_x_is_branch && |(i_x_insn[11:9] & nzp_x));

endmodule

`default_nettype wire

// File: hw/lc4_config.svh
`ifndef LC4_CONFIG_SVH
`define LC4_CONFIG_SVH

// machine word, also the address width of both memories
`define LC4_WORD_W   16

`define LC4_NUM_REGS 8        // R0 to R7
`define LC4_RSEL_W   3

// first user code address
`define LC4_RESET_PC 16'h8200

`endif

// File: hw/lc4_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module lc4_decoder (
   input  wire lc4_pkg::word_t i_insn,
   output lc4_pkg::rsel_t      o_r1sel,
   output lc4_pkg::rsel_t      o_r2sel,
   output lc4_pkg::rsel_t      o_wsel,
   output logic                o_r1re,
   output logic                o_r2re,
   output logic                o_rf_we,
   output logic                o_nzp_we,
   output logic                o_is_load,
   output logic                o_is_store,
   output logic                o_is_branch,
   output logic                o_is_jmp
);

   lc4_pkg::opcode_e opcode;

   assign opcode = lc4_pkg::opcode_e'(i_insn[15:12]);

   always_comb begin
      o_r1sel     = i_insn[8:6];
      o_r2sel     = i_insn[2:0];
      o_wsel      = i_insn[11:9];
      o_r1re      = 1'b0;
      o_r2re      = 1'b0;
      o_rf_we     = 1'b0;
      o_nzp_we    = 1'b0;
      o_is_load   = 1'b0;
      o_is_store  = 1'b0;
      o_is_branch = 1'b0;
      o_is_jmp    = 1'b0;
      case (opcode)
         lc4_pkg::OP_BR: o_is_branch = 1'b1;  // nzp mask 000 is the NOP
         lc4_pkg::OP_ARITH: begin
            // only ADD (000), SUB (010) and ADD imm5, MUL and DIV fall through as no-ops
            if (i_insn[5] || !i_insn[3]) begin
               o_r1re   = 1'b1;
               o_r2re   = !i_insn[5];
               o_rf_we  = 1'b1;
               o_nzp_we = 1'b1;
            end
         end
         lc4_pkg::OP_LOGIC: begin
            o_r1re   = 1'b1;
            o_r2re   = !i_insn[5] && (i_insn[4:3] != 2'b01);  // NOT and AND imm have one source
            o_rf_we  = 1'b1;
            o_nzp_we = 1'b1;
         end
         lc4_pkg::OP_LDR: begin
            o_r1re    = 1'b1;
            o_rf_we   = 1'b1;
            o_nzp_we  = 1'b1;
            o_is_load = 1'b1;
         end
         lc4_pkg::OP_STR: begin
            o_r1re     = 1'b1;  // base
            o_r2re     = 1'b1;
            o_r2sel    = i_insn[11:9];  // store data sits in the Rd field
            o_is_store = 1'b1;
         end
         lc4_pkg::OP_CONST: begin
            o_rf_we  = 1'b1;
            o_nzp_we = 1'b1;
         end
         lc4_pkg::OP_JMP: o_is_jmp = i_insn[11];  // JMPR form is not implemented
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// File: hw/lc4_hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

module lc4_hazard_unit (
   input  wire lc4_pkg::rsel_t i_d_r1sel,
   input  wire lc4_pkg::rsel_t i_d_r2sel,
   input  wire                 i_d_r1re,
   input  wire                 i_d_r2re,
   input  wire                 i_d_is_store,
   input  wire lc4_pkg::rsel_t i_x_wsel,
   input  wire                 i_x_rf_we,
   input  wire                 i_x_is_load,
   input  wire lc4_pkg::rsel_t i_x_r1sel,
   input  wire lc4_pkg::rsel_t i_x_r2sel,
   input  wire                 i_x_r1re,
   input  wire                 i_x_r2re,
   input  wire lc4_pkg::rsel_t i_m_wsel,
   input  wire                 i_m_rf_we,
   input  wire                 i_m_is_store,
   input  wire lc4_pkg::rsel_t i_m_r2sel,
   input  wire lc4_pkg::rsel_t i_w_wsel,
   input  wire                 i_w_rf_we,
   input  wire                 i_taken,
   output logic                o_stall_load,
   output logic                o_flush,
   output logic                o_bp1_m,
   output logic                o_bp1_w,
   output logic                o_bp2_m,
   output logic                o_bp2_w,
   output logic                o_bp_store
);

   logic use_r1;
   logic use_r2;

   // store data is picked up later by the WM path, so only its base can stall
   assign use_r1 = i_d_r1re && (i_d_r1sel == i_x_wsel);
   assign use_r2 = i_d_r2re && (i_d_r2sel == i_x_wsel) && !i_d_is_store;

   assign o_stall_load = i_x_is_load && i_x_rf_we && (use_r1 || use_r2);
   assign o_flush      = i_taken;

   // MX wins over WX, the memory stage holds the younger value
   assign o_bp1_m = i_x_r1re && i_m_rf_we && (i_x_r1sel == i_m_wsel);
   assign o_bp2_m = i_x_r2re && i_m_rf_we && (i_x_r2sel == i_m_wsel);
   assign o_bp1_w = i_x_r1re && i_w_rf_we && (i_x_r1sel == i_w_wsel) && !o_bp1_m;
   assign o_bp2_w = i_x_r2re && i_w_rf_we && (i_x_r2sel == i_w_wsel) && !o_bp2_m;

   assign o_bp_store = i_m_is_store && i_w_rf_we && (i_m_r2sel == i_w_wsel);  // WM

endmodule

`default_nettype wire

// File: hw/lc4_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

`include "lc4_config.svh"

module lc4_pipeline (
   input  wire                 gwe,
   input  wire                 i_arst_n,
   output lc4_pkg::word_t      o_imem_addr,
   input  wire lc4_pkg::word_t i_imem_data,
   output lc4_pkg::word_t      o_dmem_addr,
   output logic                o_dmem_we,
   output lc4_pkg::word_t      o_dmem_wdata,
   input  wire lc4_pkg::word_t i_dmem_rdata,
   output lc4_pkg::stall_e     o_wb_stall,
   output lc4_pkg::word_t      o_wb_pc,
   output lc4_pkg::word_t      o_wb_insn,
   output logic                o_wb_rf_we,
   output lc4_pkg::rsel_t      o_wb_rf_wsel,
   output lc4_pkg::word_t      o_wb_rf_wdata,
   output logic                o_wb_nzp_we,
   output lc4_pkg::nzp_t       o_wb_nzp
);

   lc4_pkg::word_t  pc;
   lc4_pkg::word_t  d_pc, d_insn, d_r1data, d_r2data;
   lc4_pkg::stall_e d_stall;
   lc4_pkg::rsel_t  d_r1sel, d_r2sel, d_wsel;
   logic            d_r1re, d_r2re, d_rf_we, d_nzp_we;
   logic            d_is_load, d_is_store, d_is_branch, d_is_jmp;
   lc4_pkg::word_t  x_pc, x_insn, x_r1data, x_r2data, x_op1, x_op2, x_alu;
   lc4_pkg::stall_e x_stall;
   lc4_pkg::rsel_t  x_r1sel, x_r2sel, x_wsel;
   logic            x_r1re, x_r2re, x_rf_we, x_nzp_we;
   logic            x_is_load, x_is_store, x_is_branch, x_is_jmp;
   lc4_pkg::word_t  m_pc, m_insn, m_alu, m_r2data, m_value;
   lc4_pkg::stall_e m_stall;
   lc4_pkg::rsel_t  m_r2sel, m_wsel;
   lc4_pkg::nzp_t   m_nzp;
   logic            m_rf_we, m_nzp_we, m_is_load, m_is_store;
   logic            stall_load, flush, taken, x_kill;
   logic            bp1_m, bp1_w, bp2_m, bp2_w, bp_store;

   assign x_kill = flush || stall_load;  // slot entering execute becomes a bubble

   // fetch
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc <= `LC4_RESET_PC;
      end else if (flush) begin
         pc <= x_alu;  // resolved target
      end else if (!stall_load) begin
         pc <= pc + 1'b1;
      end
   end
   assign o_imem_addr = pc;

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         d_stall <= lc4_pkg::STALL_FLUSH;
         d_pc    <= '0;
         d_insn  <= '0;
      end else if (flush) begin
         d_stall <= lc4_pkg::STALL_FLUSH;
         d_insn  <= '0;  // NOP, decodes with every enable low
      end else if (!stall_load) begin
         d_stall <= lc4_pkg::STALL_NONE;
         d_pc    <= pc;
         d_insn  <= i_imem_data;
      end
   end

   // decode
   lc4_decoder u_decoder (
      .i_insn(d_insn), .o_r1sel(d_r1sel), .o_r2sel(d_r2sel), .o_wsel(d_wsel),
      .o_r1re(d_r1re), .o_r2re(d_r2re), .o_rf_we(d_rf_we), .o_nzp_we(d_nzp_we),
      .o_is_load(d_is_load), .o_is_store(d_is_store), .o_is_branch(d_is_branch),
      .o_is_jmp(d_is_jmp)
   );

   lc4_regfile u_regfile (
      .gwe(gwe), .i_arst_n(i_arst_n),
      .i_rs(d_r1sel), .i_rt(d_r2sel), .o_rs_data(d_r1data), .o_rt_data(d_r2data),
      .i_rd(o_wb_rf_wsel), .i_wdata(o_wb_rf_wdata), .i_we(o_wb_rf_we)
   );

   lc4_hazard_unit u_hazard (
      .i_d_r1sel(d_r1sel), .i_d_r2sel(d_r2sel), .i_d_r1re(d_r1re), .i_d_r2re(d_r2re),
      .i_d_is_store(d_is_store),
      .i_x_wsel(x_wsel), .i_x_rf_we(x_rf_we), .i_x_is_load(x_is_load),
      .i_x_r1sel(x_r1sel), .i_x_r2sel(x_r2sel), .i_x_r1re(x_r1re), .i_x_r2re(x_r2re),
      .i_m_wsel(m_wsel), .i_m_rf_we(m_rf_we), .i_m_is_store(m_is_store),
      .i_m_r2sel(m_r2sel), .i_w_wsel(o_wb_rf_wsel), .i_w_rf_we(o_wb_rf_we),
      .i_taken(taken), .o_stall_load(stall_load), .o_flush(flush),
      .o_bp1_m(bp1_m), .o_bp1_w(bp1_w), .o_bp2_m(bp2_m), .o_bp2_w(bp2_w),
      .o_bp_store(bp_store)
   );

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         x_stall     <= lc4_pkg::STALL_FLUSH;
         x_pc        <= '0;
         x_insn      <= '0;
         x_r1re      <= 1'b0;
         x_r2re      <= 1'b0;
         x_rf_we     <= 1'b0;
         x_nzp_we    <= 1'b0;
         x_is_load   <= 1'b0;
         x_is_store  <= 1'b0;
         x_is_branch <= 1'b0;
         x_is_jmp    <= 1'b0;
      end else begin
         x_stall     <= flush ? lc4_pkg::STALL_FLUSH :
                        (stall_load ? lc4_pkg::STALL_LOAD : d_stall);
         x_pc        <= d_pc;
         x_insn      <= x_kill ? '0 : d_insn;
         x_r1re      <= d_r1re && !x_kill;
         x_r2re      <= d_r2re && !x_kill;
         x_rf_we     <= d_rf_we && !x_kill;
         x_nzp_we    <= d_nzp_we && !x_kill;
         x_is_load   <= d_is_load && !x_kill;
         x_is_store  <= d_is_store && !x_kill;
         x_is_branch <= d_is_branch && !x_kill;
         x_is_jmp    <= d_is_jmp && !x_kill;
      end
   end

   always_ff @(posedge gwe) begin
      x_r1sel  <= d_r1sel;
      x_r2sel  <= d_r2sel;
      x_wsel   <= d_wsel;
      x_r1data <= d_r1data;
      x_r2data <= d_r2data;
   end

   // execute
   assign x_op1 = bp1_m ? m_alu : (bp1_w ? o_wb_rf_wdata : x_r1data);
   assign x_op2 = bp2_m ? m_alu : (bp2_w ? o_wb_rf_wdata : x_r2data);

   lc4_alu u_alu (
      .i_insn(x_insn), .i_pc(x_pc), .i_r1data(x_op1), .i_r2data(x_op2), .o_result(x_alu)
   );

   lc4_branch_unit u_branch (
      .gwe(gwe), .i_arst_n(i_arst_n), .i_x_insn(x_insn),
      .i_x_is_branch(x_is_branch), .i_x_is_jmp(x_is_jmp),
      .i_m_nzp_we(m_nzp_we), .i_m_value(m_value), .o_m_nzp(m_nzp), .o_taken(taken)
   );

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         m_stall    <= lc4_pkg::STALL_FLUSH;
         m_pc       <= '0;
         m_insn     <= '0;
         m_rf_we    <= 1'b0;
         m_nzp_we   <= 1'b0;
         m_is_load  <= 1'b0;
         m_is_store <= 1'b0;
      end else begin
         m_stall    <= x_stall;
         m_pc       <= x_pc;
         m_insn     <= x_insn;
         m_rf_we    <= x_rf_we;
         m_nzp_we   <= x_nzp_we;
         m_is_load  <= x_is_load;
         m_is_store <= x_is_store;
      end
   end

   always_ff @(posedge gwe) begin
      m_r2sel  <= x_r2sel;
      m_wsel   <= x_wsel;
      m_alu    <= x_alu;
      m_r2data <= x_op2;  // store data, may be replaced by WM below
   end

   // memory
   assign o_dmem_addr  = (m_is_load || m_is_store) ? m_alu : '0;
   assign o_dmem_we    = m_is_store;
   assign o_dmem_wdata = m_is_store ? (bp_store ? o_wb_rf_wdata : m_r2data) : '0;

   // writeback data is chosen here so the nzp logic sees the same value
   assign m_value = m_is_load ? i_dmem_rdata : m_alu;

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_wb_stall  <= lc4_pkg::STALL_FLUSH;
         o_wb_pc     <= '0;
         o_wb_insn   <= '0;
         o_wb_rf_we  <= 1'b0;
         o_wb_nzp_we <= 1'b0;
      end else begin
         o_wb_stall  <= m_stall;
         o_wb_pc     <= m_pc;
         o_wb_insn   <= m_insn;
         o_wb_rf_we  <= m_rf_we;
         o_wb_nzp_we <= m_nzp_we;
      end
   end

   always_ff @(posedge gwe) begin
      o_wb_rf_wsel  <= m_wsel;
      o_wb_rf_wdata <= m_value;
      o_wb_nzp      <= m_nzp;
   end

   // a store may only reach memory from a live slot
   a_store_live_slot : assert property (@(posedge gwe) disable iff (!i_arst_n)
      o_dmem_we |-> (m_stall == lc4_pkg::STALL_NONE))
      else $error("data memory write from a bubble slot");

endmodule

`default_nettype wire

// File: hw/lc4_pkg.sv
`default_nettype none

`include "lc4_config.svh"

package lc4_pkg;

   typedef logic [`LC4_WORD_W-1:0] word_t;
   typedef logic [`LC4_RSEL_W-1:0] rsel_t;
   typedef logic [2:0]             nzp_t;  // {n, z, p}

   // insn[15:12] of the implemented subset
   typedef enum logic [3:0] {
      OP_BR    = 4'b0000,
      OP_ARITH = 4'b0001,
      OP_LOGIC = 4'b0101,
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001,
      OP_JMP   = 4'b1100
   } opcode_e;

   // status tag that travels with every pipeline slot
   // code 1 was the superscalar pairing stall and is never produced
   typedef enum logic [1:0] {
      STALL_NONE  = 2'd0,
      STALL_FLUSH = 2'd2,  // squashed by a taken branch, also the reset value
      STALL_LOAD  = 2'd3   // bubble behind a load-use hazard
   } stall_e;

endpackage

`default_nettype wire

// File: hw/lc4_regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "lc4_config.svh"

module lc4_regfile (
   input  wire                 gwe,
   input  wire                 i_arst_n,
   input  wire lc4_pkg::rsel_t i_rs,
   input  wire lc4_pkg::rsel_t i_rt,
   output lc4_pkg::word_t      o_rs_data,
   output lc4_pkg::word_t      o_rt_data,
   input  wire lc4_pkg::rsel_t i_rd,
   input  wire lc4_pkg::word_t i_wdata,
   input  wire                 i_we
);

   lc4_pkg::word_t regs [`LC4_NUM_REGS];

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < `LC4_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // write-through, so decode sees the value retiring this cycle
   assign o_rs_data = (i_we && (i_rd == i_rs)) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_we && (i_rd == i_rt)) ? i_wdata : regs[i_rt];

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/lc4_pkg.sv
hw/lc4_decoder.sv
hw/lc4_regfile.sv
hw/lc4_alu.sv
hw/lc4_branch_unit.sv
hw/lc4_hazard_unit.sv
hw/lc4_pipeline.sv
tests/lc4_pipeline_tb.sv

// File: tests/lc4_pipeline_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "lc4_config.svh"

module lc4_pipeline_tb;

   typedef struct packed {
      lc4_pkg::word_t pc;
      lc4_pkg::word_t insn;
      logic           rf_we;
      lc4_pkg::rsel_t wsel;
      lc4_pkg::word_t wdata;
      logic           nzp_we;
      lc4_pkg::nzp_t  nzp;
   } retire_t;

   typedef struct packed {
      lc4_pkg::word_t addr;
      lc4_pkg::word_t data;
   } store_t;

   logic            gwe = 1'b0;
   logic            arst_n;
   lc4_pkg::word_t  imem_addr;
   lc4_pkg::word_t  imem_data;
   lc4_pkg::word_t  dmem_addr;
   logic            dmem_we;
   lc4_pkg::word_t  dmem_wdata;
   lc4_pkg::word_t  dmem_rdata;
   lc4_pkg::stall_e wb_stall;
   lc4_pkg::word_t  wb_pc;
   lc4_pkg::word_t  wb_insn;
   logic            wb_rf_we;
   lc4_pkg::rsel_t  wb_rf_wsel;
   lc4_pkg::word_t  wb_rf_wdata;
   logic            wb_nzp_we;
   lc4_pkg::nzp_t   wb_nzp;

   lc4_pkg::word_t imem [0:65535];
   lc4_pkg::word_t dmem [0:65535];
   lc4_pkg::word_t model_dmem [0:65535];  // private copy for the ISA model
   retire_t        expected_q [$];
   store_t         stores_q [$];
   lc4_pkg::word_t build_pc;
   logic [31:0]    lcg_state = 32'd50;
   logic           retired_any = 1'b0;
   int             load_bubbles = 0;
   int             flush_bubbles = 0;

   always #10 gwe = ~gwe;

   lc4_pipeline dut_i (
      .gwe(gwe), .i_arst_n(arst_n),
      .o_imem_addr(imem_addr), .i_imem_data(imem_data),
      .o_dmem_addr(dmem_addr), .o_dmem_we(dmem_we), .o_dmem_wdata(dmem_wdata),
      .i_dmem_rdata(dmem_rdata),
      .o_wb_stall(wb_stall), .o_wb_pc(wb_pc), .o_wb_insn(wb_insn),
      .o_wb_rf_we(wb_rf_we), .o_wb_rf_wsel(wb_rf_wsel), .o_wb_rf_wdata(wb_rf_wdata),
      .o_wb_nzp_we(wb_nzp_we), .o_wb_nzp(wb_nzp)
   );

   // both memories answer in the same cycle
   assign imem_data  = imem[imem_addr];
   assign dmem_rdata = dmem[dmem_addr];

   always @(posedge gwe) begin
      if (dmem_we) begin
         dmem[dmem_addr] <= dmem_wdata;
      end
   end

   task automatic stop_with_failure(string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_equal(string field, lc4_pkg::word_t got, lc4_pkg::word_t want);
      if (got !== want) begin
         stop_with_failure($sformatf("FAIL %0t: %s is %h, expected %h", $time, field, got,
                                     want));
      end
   endtask

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic lc4_pkg::word_t fill_word(lc4_pkg::word_t a);
      return {a[7:0], a[15:8]} ^ 16'h3C5A;
   endfunction

   function automatic lc4_pkg::word_t sign_extend(lc4_pkg::word_t v, int bits);
      lc4_pkg::word_t upper;
      upper = 16'hFFFF << bits;
      return v[bits-1] ? (v | upper) : (v & ~upper);
   endfunction

   function automatic lc4_pkg::nzp_t nzp_of(lc4_pkg::word_t v);
      return v[15] ? 3'b100 : ((v == 16'd0) ? 3'b010 : 3'b001);
   endfunction

   // instruction encoders
   function automatic lc4_pkg::word_t arith_rr(logic [2:0] rd, logic [2:0] rs,
                                               logic [2:0] sub, logic [2:0] rt);
      return {4'b0001, rd, rs, sub, rt};  // sub 000 ADD, 010 SUB
   endfunction

   function automatic lc4_pkg::word_t logic_rr(logic [2:0] rd, logic [2:0] rs,
                                               logic [2:0] sub, logic [2:0] rt);
      return {4'b0101, rd, rs, sub, rt};  // AND, NOT, OR, XOR
   endfunction

   function automatic lc4_pkg::word_t imm5_op(logic [3:0] op, logic [2:0] rd,
                                              logic [2:0] rs, logic [4:0] imm);
      return {op, rd, rs, 1'b1, imm};
   endfunction

   function automatic lc4_pkg::word_t mem_op(logic [3:0] op, logic [2:0] r,
                                             logic [2:0] base, logic [5:0] imm);
      return {op, r, base, imm};
   endfunction

   function automatic lc4_pkg::word_t const_insn(logic [2:0] rd, logic [8:0] imm);
      return {4'b1001, rd, imm};
   endfunction

   function automatic lc4_pkg::word_t br_insn(logic [2:0] mask, logic [8:0] imm);
      return {4'b0000, mask, imm};
   endfunction

   function automatic lc4_pkg::word_t jmp_insn(logic [10:0] imm);
      return {4'b1100, 1'b1, imm};
   endfunction

   task automatic emit(lc4_pkg::word_t insn);
      imem[build_pc] = insn;
      build_pc = build_pc + 16'd1;
   endtask

   task automatic build_random(int count);
      int          i;
      logic [31:0] sel;
      logic [31:0] f;
      for (i = 0; i < count; i++) begin
         sel = next_random();
         f   = next_random();
         case (sel[31:16] % 10)
            0: emit(arith_rr(f[18:16], f[21:19], 3'b000, f[24:22]));
            1: emit(arith_rr(f[18:16], f[21:19], 3'b010, f[24:22]));
            2: emit(imm5_op(lc4_pkg::OP_ARITH, f[18:16], f[21:19], f[29:25]));
            3: emit(logic_rr(f[18:16], f[21:19], {1'b0, f[27:26]}, f[24:22]));
            4: emit(imm5_op(lc4_pkg::OP_LOGIC, f[18:16], f[21:19], f[29:25]));
            5: emit(const_insn(f[18:16], f[30:22]));
            6, 7: emit(mem_op(lc4_pkg::OP_LDR, f[18:16], f[21:19], f[30:25]));
            default: emit(mem_op(lc4_pkg::OP_STR, f[18:16], f[21:19], f[30:25]));
         endcase
      end
   endtask

   task automatic build_program();
      int           v;
      int           m;
      logic [8:0]   flag_vals [3];
      flag_vals = '{9'h1FE, 9'h000, 9'h009};  // negative, zero, positive
      build_pc  = `LC4_RESET_PC;
      emit(const_insn(3'd1, 9'd5));             // dependent ALU chain
      emit(const_insn(3'd2, 9'h1FD));
      emit(arith_rr(3'd3, 3'd1, 3'b000, 3'd2)); // WX on r1, MX on r2
      emit(arith_rr(3'd4, 3'd3, 3'b010, 3'd1));
      emit(logic_rr(3'd5, 3'd4, 3'b011, 3'd3));
      emit(logic_rr(3'd6, 3'd5, 3'b010, 3'd2));
      emit(logic_rr(3'd7, 3'd6, 3'b001, 3'd0));
      emit(logic_rr(3'd0, 3'd7, 3'b000, 3'd1));
      emit(imm5_op(lc4_pkg::OP_ARITH, 3'd1, 3'd0, 5'h19));
      emit(imm5_op(lc4_pkg::OP_LOGIC, 3'd2, 3'd1, 5'h0F));
      emit(const_insn(3'd6, 9'd100));
      emit(imm5_op(lc4_pkg::OP_ARITH, 3'd0, 3'd0, 5'd1));
      emit(imm5_op(lc4_pkg::OP_ARITH, 3'd0, 3'd0, 5'd1));
      emit(arith_rr(3'd7, 3'd6, 3'b000, 3'd6)); // r6 read while it retires
      emit(const_insn(3'd1, 9'h040));           // loads and stores
      emit(const_insn(3'd3, 9'h077));
      emit(mem_op(lc4_pkg::OP_STR, 3'd3, 3'd1, 6'd4));
      emit(mem_op(lc4_pkg::OP_LDR, 3'd4, 3'd1, 6'd4));  // reads the store back
      emit(arith_rr(3'd5, 3'd4, 3'b000, 3'd4)); // load-use bubble
      emit(mem_op(lc4_pkg::OP_LDR, 3'd6, 3'd1, 6'd10));
      emit(mem_op(lc4_pkg::OP_STR, 3'd6, 3'd1, 6'd11));
      emit(mem_op(lc4_pkg::OP_LDR, 3'd7, 3'd1, 6'd11));
      emit(mem_op(lc4_pkg::OP_LDR, 3'd0, 3'd7, 6'd0));  // base from a load
      emit(arith_rr(3'd0, 3'd0, 3'b000, 3'd7));
      emit(mem_op(lc4_pkg::OP_LDR, 3'd4, 3'd1, 6'd4));
      emit(br_insn(3'b001, 9'd1));              // branch on load data
      emit(const_insn(3'd2, 9'd1));
      // every mask against every flag value
      for (v = 0; v < 3; v++) begin
         for (m = 0; m < 8; m++) begin
            emit(const_insn(3'd1, flag_vals[v]));
            emit(br_insn(m[2:0], 9'd1));
            emit(const_insn(3'd2, {6'd0, m[2:0]}));  // skipped when taken
            emit(imm5_op(lc4_pkg::OP_ARITH, 3'd3, 3'd2, 5'd1));
         end
      end
      emit(const_insn(3'd1, 9'h1FE));
      emit(br_insn(3'b000, 9'd0));              // NOP, flags come from the register
      emit(br_insn(3'b100, 9'd1));
      emit(const_insn(3'd2, 9'd3));
      emit(const_insn(3'd5, 9'd3));             // backward loop, three passes
      emit(imm5_op(lc4_pkg::OP_ARITH, 3'd5, 3'd5, 5'h1F));
      emit(br_insn(3'b001, 9'h1FE));
      emit(jmp_insn(11'd2));
      emit(const_insn(3'd6, 9'd1));
      emit(const_insn(3'd6, 9'd2));
      build_random(200);
      emit(jmp_insn(11'h7FF));                  // jump to itself ends the program
   endtask

   // ISA-level model, one entry per retired instruction
   function automatic void run_model();
      lc4_pkg::word_t regs [8];
      lc4_pkg::word_t pc;
      lc4_pkg::word_t next_pc;
      lc4_pkg::word_t insn;
      lc4_pkg::word_t res;
      lc4_pkg::word_t rs_val;
      lc4_pkg::word_t rt_val;
      lc4_pkg::nzp_t  flags;
      retire_t        slot;
      store_t         st;
      int             i;
      pc    = `LC4_RESET_PC;
      flags = 3'b000;
      for (i = 0; i < 8; i++) begin
         regs[i] = '0;
      end
      for (i = 0; i < 5000; i++) begin
         insn    = imem[pc];
         rs_val  = regs[insn[8:6]];
         rt_val  = regs[insn[2:0]];
         next_pc = pc + 16'd1;
         res     = '0;
         slot    = '0;
         slot.pc   = pc;
         slot.insn = insn;
         case (insn[15:12])
            4'b0001: begin
               slot.rf_we = 1'b1;
               res = insn[5] ? rs_val + sign_extend(insn, 5) :
                     (insn[4:3] == 2'b10) ? rs_val - rt_val : rs_val + rt_val;
            end
            4'b0101: begin
               slot.rf_we = 1'b1;
               res = insn[5] ? rs_val & sign_extend(insn, 5) :
                     (insn[4:3] == 2'b00) ? rs_val & rt_val :
                     (insn[4:3] == 2'b01) ? ~rs_val :
                     (insn[4:3] == 2'b10) ? rs_val | rt_val : rs_val ^ rt_val;
            end
            4'b0110: begin
               slot.rf_we = 1'b1;
               res = model_dmem[rs_val + sign_extend(insn, 6)];
            end
            4'b0111: begin
               st.addr = rs_val + sign_extend(insn, 6);
               st.data = regs[insn[11:9]];
               model_dmem[st.addr] = st.data;
               stores_q.push_back(st);
            end
            4'b1001: begin
               slot.rf_we = 1'b1;
               res = sign_extend(insn, 9);
            end
            4'b0000: begin
               if (|(insn[11:9] & flags)) begin
                  next_pc = pc + 16'd1 + sign_extend(insn, 9);
               end
            end
            4'b1100: next_pc = pc + 16'd1 + sign_extend(insn, 11);
            default: ;
         endcase
         if (slot.rf_we) begin
            regs[insn[11:9]] = res;
            flags       = nzp_of(res);
            slot.wsel   = insn[11:9];
            slot.wdata  = res;
            slot.nzp_we = 1'b1;
            slot.nzp    = flags;
         end
         expected_q.push_back(slot);
         if (next_pc == pc) begin
            break;
         end
         pc = next_pc;
      end
   endfunction

   // compare every writeback slot and every store against the model
   always @(negedge gwe) begin
      retire_t want;
      store_t  st;
      if (arst_n) begin
         check_equal("reserved stall code", wb_stall == 2'd1, 1'b0);
         if (wb_stall == lc4_pkg::STALL_NONE) begin
            if (expected_q.size() == 0) begin
               stop_with_failure("an instruction retired after the program had ended");
            end else begin
               want = expected_q.pop_front();
               check_equal("wb pc", wb_pc, want.pc);
               check_equal("wb insn", wb_insn, want.insn);
               check_equal("wb rf_we", wb_rf_we, want.rf_we);
               check_equal("wb nzp_we", wb_nzp_we, want.nzp_we);
               if (want.rf_we) begin
                  check_equal("wb rf_wsel", wb_rf_wsel, want.wsel);
                  check_equal("wb rf_wdata", wb_rf_wdata, want.wdata);
                  check_equal("wb nzp", wb_nzp, want.nzp);
               end
               retired_any = 1'b1;
            end
         end else begin
            check_equal("bubble rf_we", wb_rf_we, 1'b0);
            check_equal("bubble nzp_we", wb_nzp_we, 1'b0);
            if (wb_stall == lc4_pkg::STALL_LOAD) begin
               load_bubbles++;
            end else if (retired_any) begin
               flush_bubbles++;  // reset bubbles are not branch flushes
            end
         end
         if (!retired_any) begin
            check_equal("dmem_we before first retirement", dmem_we, 1'b0);
         end
         if (dmem_we) begin
            if (stores_q.size() == 0) begin
               stop_with_failure("data memory write that the program never issues");
            end else begin
               st = stores_q.pop_front();
               check_equal("store address", dmem_addr, st.addr);
               check_equal("store data", dmem_wdata, st.data);
            end
         end
      end
   end

   initial begin
      int a;
      int cycles;
      arst_n = 1'b0;
      for (a = 0; a < 65536; a++) begin
         imem[a]       = 16'h0000;  // NOP
         dmem[a]       = fill_word(a[15:0]);
         model_dmem[a] = fill_word(a[15:0]);
      end
      build_program();
      run_model();
      repeat (4) @(posedge gwe);
      arst_n <= 1'b1;
      @(negedge gwe);
      check_equal("first fetch address", imem_addr, 16'h8200);
      cycles = 0;
      while (expected_q.size() != 0 || stores_q.size() != 0) begin
         @(posedge gwe);
         cycles++;
         if (cycles > 5000) begin
            stop_with_failure("timeout: the pipeline stopped retiring the expected program");
         end
      end
      check_equal("load-use bubble seen", load_bubbles != 0, 1'b1);
      check_equal("flushed slot seen", flush_bubbles != 0, 1'b1);
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire
